// File: include/eq_coefs.svh
`ifndef EQ_COEFS_SVH
`define EQ_COEFS_SVH

// Fixed bandpass coefficients in Q2.16, one entry per band
localparam logic signed [coef_w-1:0] eq_a1_c [num_bands_c] = '{
  18'b10_0000_0011_0001_0011, // 10 Hz to 100 Hz
  18'b10_0000_1101_0100_1010, // 100 Hz to 500 Hz
  18'b10_0001_0010_0101_1011, // 500 Hz to 1 kHz
  18'b10_0111_1101_1100_0110, // 1 kHz to 5 kHz
  18'b11_0001_1111_1011_1111, // 5 kHz to 10 kHz
  18'b00_1000_1011_1100_0000  // 10 kHz to 20 kHz
};
localparam logic signed [coef_w-1:0] eq_a2_c [num_bands_c] = '{
  18'b00_1111_1101_0000_0001,
  18'b00_1111_0010_1111_0001,
  18'b00_1110_1111_1100_0101,
  18'b00_1001_0011_1101_0000,
  18'b00_0111_1110_0011_1011,
  18'b00_0010_0001_1011_0111
};
localparam logic signed [coef_w-1:0] eq_b0_c [num_bands_c] = '{
  18'b00_0000_0001_1000_0010,
  18'b00_0000_0110_1000_0111,
  18'b00_0000_1000_0001_1101,
  18'b00_0011_0110_0001_0111,
  18'b00_0100_0000_1101_1110,
  18'b00_0110_1111_0010_0111
};
// Bandpass shape, so the middle tap is zero everywhere
localparam logic signed [coef_w-1:0] eq_b1_c [num_bands_c] = '{
  18'b0, 18'b0, 18'b0, 18'b0, 18'b0, 18'b0
};
localparam logic signed [coef_w-1:0] eq_b2_c [num_bands_c] = '{
  18'b11_1111_1110_0111_1110,
  18'b11_1111_1001_0111_1001,
  18'b11_1111_0111_1110_0011,
  18'b11_1100_1001_1110_1001,
  18'b11_1011_1111_0010_0010,
  18'b11_1001_0000_1101_1001
};

`endif

// File: src/audio_eq_pkg.sv
package audio_eq_pkg;

  localparam int sample_w = 16;    // Signed audio sample
  localparam int coef_w = 18;      // Signed Q2.16
  localparam int state_w = 19;     // Sample plus three guard bits
  localparam int gain_w = 8;       // Unsigned Q1.7
  localparam int power_w = 8;
  localparam int num_bands_c = 6;

  // Unity gain
  localparam logic [gain_w-1:0] gain_reset_c = gain_w'(128);

  typedef struct packed {
    logic signed [coef_w-1:0] a1;
    logic signed [coef_w-1:0] a2;
    logic signed [coef_w-1:0] b0;
    logic signed [coef_w-1:0] b1;
    logic signed [coef_w-1:0] b2;
  } band_coefs_t;

  `include "eq_coefs.svh"

  // Unknown band numbers fall back to the lowest band
  function automatic band_coefs_t get_band_coefs(input int band);
    band_coefs_t c;
    int idx;
    idx = (band >= 0 && band < num_bands_c) ? band : 0;
    c.a1 = eq_a1_c[idx];
    c.a2 = eq_a2_c[idx];
    c.b0 = eq_b0_c[idx];
    c.b1 = eq_b1_c[idx];
    c.b2 = eq_b2_c[idx];
    return c;
  endfunction

endpackage

// File: src/eq_ctrl.sv
`timescale 1ns/100ps

module eq_ctrl import audio_eq_pkg::*; #(
  parameter int NUM_BANDS = num_bands_c
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              sample_valid,
  input  logic                              enable,
  input  logic                              cfg_write,
  input  logic [2:0]                        cfg_addr,
  input  logic [gain_w-1:0]                 cfg_data,
  output logic                              filt_step,
  output logic                              filt_clear,
  output logic                              mix_step,
  output logic                              bypass,
  output logic [NUM_BANDS-1:0][gain_w-1:0]  gains,
  output logic                              out_valid
);

  logic enable_d1;
  logic enable_d2;

  // Sample strobe pipeline, one stage per datapath step
  always_ff @(posedge clk) begin
    if (reset) begin
      filt_step <= 1'b0;
      mix_step <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      filt_step <= sample_valid;
      mix_step <= filt_step;
      out_valid <= mix_step;
    end
  end

  // Enable follows the sample down the pipe so bypass lines up with mix_step
  always_ff @(posedge clk) begin
    if (reset) begin
      enable_d1 <= 1'b0;
      enable_d2 <= 1'b0;
      filt_clear <= 1'b0;
    end else begin
      enable_d1 <= enable;
      enable_d2 <= enable_d1;
      filt_clear <= enable & ~enable_d1;  // One pulse per rising edge
    end
  end

  assign bypass = ~enable_d2;

  // Gain registers, addresses past the last band are dropped
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int b = 0; b < NUM_BANDS; b++) begin
        gains[b] <= gain_reset_c;
      end
    end else if (cfg_write) begin
      for (int b = 0; b < NUM_BANDS; b++) begin
        if (int'(cfg_addr) == b) begin
          gains[b] <= cfg_data;
        end
      end
    end
  end

endmodule

// File: src/biquad_band.sv
`timescale 1ns/100ps

module biquad_band import audio_eq_pkg::*; #(
  parameter int BAND_ID = 0
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       filt_step,
  input  logic                       filt_clear,
  input  logic signed [sample_w-1:0] in_l,
  input  logic signed [sample_w-1:0] in_r,
  output logic signed [sample_w-1:0] band_l,
  output logic signed [sample_w-1:0] band_r
);

  localparam int frac_w = coef_w - 2;
  localparam int sum_w = state_w + 2;    // Room for three terms without overflow
  localparam band_coefs_t coefs = get_band_coefs(BAND_ID);

  localparam logic signed [sum_w-1:0] state_max_c = sum_w'((2 ** (state_w - 1)) - 1);
  localparam logic signed [sum_w-1:0] state_min_c = sum_w'(-(2 ** (state_w - 1)));
  localparam logic signed [sum_w-1:0] sample_max_c = sum_w'((2 ** (sample_w - 1)) - 1);
  localparam logic signed [sum_w-1:0] sample_min_c = sum_w'(-(2 ** (sample_w - 1)));

  // State times coefficient, back to state scale
  function automatic logic signed [state_w-1:0] coef_mult(
    input logic signed [state_w-1:0] s,
    input logic signed [coef_w-1:0]  c
  );
    logic signed [state_w+coef_w-1:0] prod;
    prod = s * c;
    return prod[frac_w +: state_w];
  endfunction

  function automatic logic signed [state_w-1:0] sat_state(input logic signed [sum_w-1:0] x);
    if (x > state_max_c) begin
      return state_max_c[state_w-1:0];
    end else if (x < state_min_c) begin
      return state_min_c[state_w-1:0];
    end
    return x[state_w-1:0];
  endfunction

  function automatic logic signed [sample_w-1:0] sat_sample(input logic signed [sum_w-1:0] x);
    if (x > sample_max_c) begin
      return sample_max_c[sample_w-1:0];
    end else if (x < sample_min_c) begin
      return sample_min_c[sample_w-1:0];
    end
    return x[sample_w-1:0];
  endfunction

  logic signed [sample_w-1:0] ch_in [2];
  logic signed [sample_w-1:0] ch_out [2];

  assign ch_in[0] = in_l;
  assign ch_in[1] = in_r;
  assign band_l = ch_out[0];
  assign band_r = ch_out[1];

  for (genvar ch = 0; ch < 2; ch++) begin : g_chan
    logic signed [state_w-1:0]  v;
    logic signed [state_w-1:0]  v1;
    logic signed [state_w-1:0]  v2;
    logic signed [sum_w-1:0]    fb_sum;
    logic signed [sum_w-1:0]    ff_sum;
    logic signed [sample_w-1:0] y;

    // Recursive part
    assign fb_sum = sum_w'(ch_in[ch])
                  - sum_w'(coef_mult(v1, coefs.a1))
                  - sum_w'(coef_mult(v2, coefs.a2));

    // Output taps use the state before this step's update
    assign ff_sum = sum_w'(coef_mult(v, coefs.b0))
                  + sum_w'(coef_mult(v1, coefs.b1))
                  + sum_w'(coef_mult(v2, coefs.b2));

    always_ff @(posedge clk) begin
      if (reset || filt_clear) begin
        v <= '0;
        v1 <= '0;
        v2 <= '0;
        y <= '0;
      end else if (filt_step) begin
        v <= sat_state(fb_sum);
        v1 <= v;
        v2 <= v1;
        y <= sat_sample(ff_sum);
      end
    end

    assign ch_out[ch] = y;
  end

endmodule

// File: src/band_power.sv
`timescale 1ns/100ps

module band_power import audio_eq_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       filt_step,
  input  logic                       filt_clear,
  input  logic signed [sample_w-1:0] band_l,
  input  logic signed [sample_w-1:0] band_r,
  output logic [power_w-1:0]         level
);

  localparam int acc_w = 20;
  localparam int leak_shift = 4;   // Time constant of 16 samples

  logic [sample_w:0]   abs_l;      // One extra bit so -32768 fits
  logic [sample_w:0]   abs_r;
  logic [sample_w+1:0] rect_sum;
  logic [acc_w-1:0]    acc;

  assign abs_l = band_l[sample_w-1] ? -((sample_w + 1)'(band_l)) : (sample_w + 1)'(band_l);
  assign abs_r = band_r[sample_w-1] ? -((sample_w + 1)'(band_r)) : (sample_w + 1)'(band_r);
  assign rect_sum = (sample_w + 2)'(abs_l) + (sample_w + 2)'(abs_r);

  // Leaky average, settles at 16 times the mean half sum
  always_ff @(posedge clk) begin
    if (reset || filt_clear) begin
      acc <= '0;
    end else if (filt_step) begin
      acc <= acc - (acc >> leak_shift) + acc_w'(rect_sum >> 1);
    end
  end

  assign level = acc[acc_w-1 -: power_w];

endmodule

// File: src/band_mixer.sv
`timescale 1ns/100ps

module band_mixer import audio_eq_pkg::*; #(
  parameter int NUM_BANDS = num_bands_c
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               mix_step,
  input  logic                               bypass,
  input  logic [NUM_BANDS-1:0][gain_w-1:0]   gains,
  input  logic [NUM_BANDS-1:0][sample_w-1:0] bands_l,
  input  logic [NUM_BANDS-1:0][sample_w-1:0] bands_r,
  input  logic signed [sample_w-1:0]         dry_l,
  input  logic signed [sample_w-1:0]         dry_r,
  output logic signed [sample_w-1:0]         out_l,
  output logic signed [sample_w-1:0]         out_r
);

  localparam int prod_w = sample_w + gain_w + 1;
  localparam int acc_w = prod_w + $clog2(NUM_BANDS + 1);
  localparam int gain_frac_w = gain_w - 1;

  localparam logic signed [acc_w-1:0] sat_max_c = acc_w'((2 ** (sample_w - 1)) - 1);
  localparam logic signed [acc_w-1:0] sat_min_c = acc_w'(-(2 ** (sample_w - 1)));

  function automatic logic signed [sample_w-1:0] sat_sample(input logic signed [acc_w-1:0] x);
    if (x > sat_max_c) begin
      return sat_max_c[sample_w-1:0];
    end else if (x < sat_min_c) begin
      return sat_min_c[sample_w-1:0];
    end
    return x[sample_w-1:0];
  endfunction

  logic signed [acc_w-1:0] sum_l;
  logic signed [acc_w-1:0] sum_r;

  // Weighted sum over all bands
  always_comb begin
    logic signed [prod_w-1:0] prod_l;
    logic signed [prod_w-1:0] prod_r;
    sum_l = '0;
    sum_r = '0;
    for (int b = 0; b < NUM_BANDS; b++) begin
      // Gain is unsigned, zero extend before the signed multiply
      prod_l = $signed(bands_l[b]) * $signed({1'b0, gains[b]});
      prod_r = $signed(bands_r[b]) * $signed({1'b0, gains[b]});
      sum_l = sum_l + acc_w'(prod_l);
      sum_r = sum_r + acc_w'(prod_r);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_l <= '0;
      out_r <= '0;
    end else if (mix_step) begin
      if (bypass) begin
        out_l <= dry_l;
        out_r <= dry_r;
      end else begin
        out_l <= sat_sample(sum_l >>> gain_frac_w);   // Back to Q1.7 unity
        out_r <= sat_sample(sum_r >>> gain_frac_w);
      end
    end
  end

endmodule

// File: src/audio_eq_top.sv
`timescale 1ns/100ps

module audio_eq_top import audio_eq_pkg::*; #(
  parameter int NUM_BANDS = num_bands_c
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               sample_valid,
  input  logic signed [sample_w-1:0]         in_l,
  input  logic signed [sample_w-1:0]         in_r,
  input  logic                               enable,
  input  logic                               cfg_write,
  input  logic [2:0]                         cfg_addr,
  input  logic [gain_w-1:0]                  cfg_data,
  output logic                               out_valid,
  output logic signed [sample_w-1:0]         out_l,
  output logic signed [sample_w-1:0]         out_r,
  output logic [NUM_BANDS-1:0][power_w-1:0]  band_power
);

  logic                               filt_step;
  logic                               filt_clear;
  logic                               mix_step;
  logic                               bypass;
  logic [NUM_BANDS-1:0][gain_w-1:0]   gains;
  logic [NUM_BANDS-1:0][sample_w-1:0] bands_l;
  logic [NUM_BANDS-1:0][sample_w-1:0] bands_r;

  logic signed [sample_w-1:0] samp_l;   // Valid during filt_step
  logic signed [sample_w-1:0] samp_r;
  logic signed [sample_w-1:0] dry_l;    // Valid during mix_step
  logic signed [sample_w-1:0] dry_r;

  // Input sample capture, a second stage keeps back-to-back samples apart
  always_ff @(posedge clk) begin
    if (sample_valid) begin
      samp_l <= in_l;
      samp_r <= in_r;
    end
    if (filt_step) begin
      dry_l <= samp_l;
      dry_r <= samp_r;
    end
  end

  eq_ctrl #(
    .NUM_BANDS(NUM_BANDS)
  ) u_ctrl (
    .clk         (clk),
    .reset       (reset),
    .sample_valid(sample_valid),
    .enable      (enable),
    .cfg_write   (cfg_write),
    .cfg_addr    (cfg_addr),
    .cfg_data    (cfg_data),
    .filt_step   (filt_step),
    .filt_clear  (filt_clear),
    .mix_step    (mix_step),
    .bypass      (bypass),
    .gains       (gains),
    .out_valid   (out_valid)
  );

  for (genvar i = 0; i < NUM_BANDS; i++) begin : g_band
    biquad_band #(
      .BAND_ID(i)
    ) u_biquad (
      .clk       (clk),
      .reset     (reset),
      .filt_step (filt_step),
      .filt_clear(filt_clear),
      .in_l      (samp_l),
      .in_r      (samp_r),
      .band_l    (bands_l[i]),
      .band_r    (bands_r[i])
    );

    band_power u_power (
      .clk       (clk),
      .reset     (reset),
      .filt_step (filt_step),
      .filt_clear(filt_clear),
      .band_l    (bands_l[i]),
      .band_r    (bands_r[i]),
      .level     (band_power[i])
    );
  end

  band_mixer #(
    .NUM_BANDS(NUM_BANDS)
  ) u_mixer (
    .clk     (clk),
    .reset   (reset),
    .mix_step(mix_step),
    .bypass  (bypass),
    .gains   (gains),
    .bands_l (bands_l),
    .bands_r (bands_r),
    .dry_l   (dry_l),
    .dry_r   (dry_r),
    .out_l   (out_l),
    .out_r   (out_r)
  );

endmodule

// File: verification/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
  parameter real PERIOD = 20.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always begin
    #(PERIOD / 2.0);
    clk = ~clk;
  end

endmodule

// File: verification/tb_audio_eq.sv
`timescale 1ns/100ps

module tb_audio_eq import audio_eq_pkg::*; ();

  localparam int nb = num_bands_c;
  localparam int seed_c = 10;
  localparam int cycle_limit_c = 6000;   // Several times the stimulus length

  logic clk, reset, sample_valid, enable, cfg_write, out_valid;
  logic signed [sample_w-1:0] in_l, in_r, out_l, out_r;
  logic [2:0] cfg_addr;
  logic [gain_w-1:0] cfg_data;
  logic [nb-1:0][power_w-1:0] band_power;

  // Reference model state
  longint st_v [nb][2];
  longint st_v1 [nb][2];
  longint st_v2 [nb][2];
  longint y_m [nb][2];
  longint acc_m [nb];
  int gain_m [nb];
  bit enable_m;
  longint exp_l [$];
  longint exp_r [$];
  logic [nb*power_w-1:0] exp_pow [$];

  logic rst_q, seen, sv_d1, sv_d2, sv_d3;
  int cycles, sat_cnt;

  tb_clock #(.PERIOD(20.0)) u_clock (.clk(clk));

  audio_eq_top #(.NUM_BANDS(nb)) u_dut (
    .clk(clk), .reset(reset), .sample_valid(sample_valid), .in_l(in_l), .in_r(in_r),
    .enable(enable), .cfg_write(cfg_write), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
    .out_valid(out_valid), .out_l(out_l), .out_r(out_r), .band_power(band_power)
  );

  task automatic report_mismatch(input string name, input longint expv, input longint act);
    $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, expv, act);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    $display("Error at t=%0t: %s", $time, why);
    $display("** FAIL **");
    $fatal(1);
  endtask

  function automatic longint wrap_state(input longint x);
    longint m;
    m = x & 64'h7FFFF;
    if (m >= 64'h40000) m = m - 64'h80000;   // Sign of bit 18
    return m;
  endfunction

  function automatic longint coef_product(input longint s, input longint c);
    return wrap_state((s * c) >>> 16);
  endfunction

  function automatic longint clamp(input longint x, input longint lo, input longint hi);
    return (x > hi) ? hi : ((x < lo) ? lo : x);
  endfunction

  function automatic longint magnitude(input longint x);
    return (x < 0) ? -x : x;
  endfunction

  task automatic clear_model();
    for (int b = 0; b < nb; b++) begin
      acc_m[b] = 0;
      for (int ch = 0; ch < 2; ch++) begin
        st_v[b][ch] = 0;
        st_v1[b][ch] = 0;
        st_v2[b][ch] = 0;
        y_m[b][ch] = 0;
      end
    end
  endtask

  // Runs one sample through the model and queues the expected results
  task automatic model_step(input longint l, input longint r);
    band_coefs_t c;
    longint x, fb, ff, sum_l, sum_r;
    logic [nb*power_w-1:0] pw;
    for (int b = 0; b < nb; b++) begin
      c = get_band_coefs(b);
      // Power sees the band outputs from before this step
      acc_m[b] = (acc_m[b] - (acc_m[b] >> 4)
                 + ((magnitude(y_m[b][0]) + magnitude(y_m[b][1])) >> 1)) & 64'hFFFFF;
      pw[b*power_w +: power_w] = power_w'(acc_m[b] >> 12);
      for (int ch = 0; ch < 2; ch++) begin
        x = (ch == 0) ? l : r;
        fb = x - coef_product(st_v1[b][ch], longint'($signed(c.a1)))
               - coef_product(st_v2[b][ch], longint'($signed(c.a2)));
        ff = coef_product(st_v[b][ch], longint'($signed(c.b0)))
           + coef_product(st_v1[b][ch], longint'($signed(c.b1)))
           + coef_product(st_v2[b][ch], longint'($signed(c.b2)));
        st_v2[b][ch] = st_v1[b][ch];
        st_v1[b][ch] = st_v[b][ch];
        st_v[b][ch] = clamp(fb, -262144, 262143);
        y_m[b][ch] = clamp(ff, -32768, 32767);
      end
    end
    sum_l = 0;
    sum_r = 0;
    for (int b = 0; b < nb; b++) begin
      sum_l += y_m[b][0] * gain_m[b];
      sum_r += y_m[b][1] * gain_m[b];
    end
    exp_l.push_back(enable_m ? clamp(sum_l >>> 7, -32768, 32767) : l);
    exp_r.push_back(enable_m ? clamp(sum_r >>> 7, -32768, 32767) : r);
    exp_pow.push_back(pw);
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic drive_sample(input longint l, input longint r);
    sample_valid = 1'b1;
    in_l = sample_w'(l);
    in_r = sample_w'(r);
    model_step(l, r);
    @(negedge clk);
    sample_valid = 1'b0;
  endtask

  task automatic random_samples(input int n, input int max_gap);
    for (int i = 0; i < n; i++) begin
      drive_sample(longint'($signed(16'($urandom))), longint'($signed(16'($urandom))));
      idle($urandom_range(max_gap, 0));   // Zero gap gives back-to-back strobes
    end
    idle(5);
  endtask

  task automatic write_gain(input int addr, input int data);
    cfg_write = 1'b1;
    cfg_addr = 3'(addr);
    cfg_data = gain_w'(data);
    @(negedge clk);
    cfg_write = 1'b0;
    if (addr < nb) gain_m[addr] = data;
  endtask

  task automatic set_enable(input bit e);
    if (e && !enable_m) clear_model();   // Rising edge clears the filters
    enable = e;
    enable_m = e;
    idle(4);
  endtask

  // Strobe delay line clocked on the same edge as the DUT
  always @(posedge clk) begin
    rst_q <= reset;
    cycles <= cycles + 1;
    if (cycles >= cycle_limit_c) abort_run("cycle limit reached before the tests finished");
    if (reset) begin
      {seen, sv_d1, sv_d2, sv_d3} <= '0;
    end else begin
      seen <= seen | sample_valid;
      sv_d1 <= sample_valid;
      sv_d2 <= sv_d1;
      sv_d3 <= sv_d2;
    end
  end

  always @(negedge clk) begin
    if (!rst_q) begin
      assert (out_valid === sv_d3) else report_mismatch("out_valid", sv_d3, out_valid);
      if (!seen) begin
        assert (out_l === '0) else report_mismatch("out_l", 0, out_l);
        assert (out_r === '0) else report_mismatch("out_r", 0, out_r);
        assert (band_power === '0) else report_mismatch("band_power", 0, band_power);
      end
      if (sv_d2) begin
        if (exp_pow.size() == 0) abort_run("power update with no expected value queued");
        for (int b = 0; b < nb; b++) begin
          assert (band_power[b] === exp_pow[0][b*power_w +: power_w])
            else report_mismatch($sformatf("band_power[%0d]", b),
                                 exp_pow[0][b*power_w +: power_w], band_power[b]);
        end
        void'(exp_pow.pop_front());
      end
      if (out_valid) begin
        if (exp_l.size() == 0) abort_run("out_valid with no expected sample queued");
        assert (out_l === sample_w'(exp_l[0])) else report_mismatch("out_l", exp_l[0], out_l);
        assert (out_r === sample_w'(exp_r[0])) else report_mismatch("out_r", exp_r[0], out_r);
        if (enable_m && (out_l == 16'sh7fff || out_l == -16'sh8000)) sat_cnt++;
        void'(exp_l.pop_front());
        void'(exp_r.pop_front());
      end
    end
  end

  initial begin
    int sel;
    void'($urandom(seed_c));
    reset = 1'b1;
    sample_valid = 1'b0;
    enable = 1'b0;
    cfg_write = 1'b0;
    in_l = '0;
    in_r = '0;
    cfg_addr = '0;
    cfg_data = '0;
    rst_q = 1'b1;
    {seen, sv_d1, sv_d2, sv_d3} = '0;
    cycles = 0;
    sat_cnt = 0;
    enable_m = 1'b0;
    clear_model();
    for (int b = 0; b < nb; b++) gain_m[b] = 128;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    idle(6);
    random_samples(60, 2);                     // Bypass path
    set_enable(1'b1);
    random_samples(200, 2);                    // Unity gains
    sel = $urandom_range(nb - 1, 0);
    for (int b = 0; b < nb; b++) write_gain(b, (b == sel) ? $urandom_range(255, 0) : 0);
    write_gain(6, $urandom_range(255, 0));     // Unmapped addresses
    write_gain(7, $urandom_range(255, 0));
    random_samples(150, 2);
    set_enable(1'b0);
    random_samples(20, 1);
    set_enable(1'b1);
    assert (band_power === '0) else report_mismatch("band_power", 0, band_power);
    random_samples(20, 1);
    for (int b = 0; b < nb; b++) write_gain(b, 255);
    for (int i = 0; i < 160; i++) begin
      drive_sample(((i / 16) % 2) ? -32768 : 32767, ((i / 16) % 2) ? 32767 : -32768);
      idle(i % 2);
    end
    idle(8);
    if (exp_l.size() == 0 && exp_pow.size() == 0 && sat_cnt > 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("Samples left unchecked or no saturated output seen");
      $display("** FAIL **");
      $fatal(1);
    end
  end

endmodule

// File: filelist.f
+incdir+include
src/audio_eq_pkg.sv
src/eq_ctrl.sv
src/biquad_band.sv
src/band_power.sv
src/band_mixer.sv
src/audio_eq_top.sv
verification/tb_clock.sv
verification/tb_audio_eq.sv

// File: Makefile
# Verilator build and run for the stereo equalizer testbench

TOP     := tb_audio_eq
OBJ_DIR := obj_dir

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): filelist.f src/*.sv include/*.svh verification/*.sv
	verilator --binary --timing -Wno-fatal --top-module $(TOP) \
	  -Mdir $(OBJ_DIR) -f filelist.f

# Exit status of the simulator is the test result
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
